//--- system_config.svh
`ifndef SYSTEM_CONFIG_SVH
`define SYSTEM_CONFIG_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define WB_AW 32
`define WB_DW 32
`define WB_SW 4

// Data RAM word address width, 1024 words
`define DMEM_AW 10

// Peripheral sizes
`define GPIO_W 8
`define IRQ_W 8

// ------------------------------------------------------------
// Memory map on address bits 15 to 12
// ------------------------------------------------------------
`define MAP_DMEM 4'd0
`define MAP_PIC 4'd1
`define MAP_GPIO 4'd2

`endif

//--- wb_pkg.sv
package wb_pkg;

    // Slave targets of the data bus
    typedef enum logic [1:0] {
        SLV_DMEM = 2'd0,
        SLV_PIC  = 2'd1,
        SLV_GPIO = 2'd2,
        SLV_NONE = 2'd3
    } slave_sel_e;

    // Decoder FSM
    typedef enum logic {
        DEC_IDLE = 1'b0,
        DEC_WAIT = 1'b1
    } dec_state_e;

    // Register word offsets, taken from address bits 3 and 2
    typedef enum logic [1:0] {
        REG_PEND    = 2'd0,
        REG_MASK    = 2'd1,
        REG_GPIO_IN = 2'd2
    } reg_ofs_e;

    // GPIO registers sit on the same offsets as the PIC registers
    localparam reg_ofs_e REG_GPIO_OUT = REG_PEND;
    localparam reg_ofs_e REG_GPIO_DIR = REG_MASK;

endpackage

//--- wb_bus_if.sv
`include "system_config.svh"

// Request side, from the decoder to the slaves and the result stage
interface wb_req_if;
    import wb_pkg::*;

    logic [`WB_AW-1:0] adr;
    logic [`WB_DW-1:0] dat_w;
    logic [`WB_SW-1:0] sel;
    logic              we;
    // One strobe bit per slave
    logic [SLV_GPIO:0] stb;
    slave_sel_e        tgt;
    // High for one cycle per accepted request
    logic              issue;

    modport decoder (output adr, dat_w, sel, we, stb, tgt, issue);
    modport slave   (input adr, dat_w, sel, we, stb);
    modport result  (input tgt, issue);
endinterface

// Response side, from the slaves to the result stage
interface wb_rsp_if;
    logic [`WB_DW-1:0] dmem_dat;
    logic              dmem_ack;
    logic [`WB_DW-1:0] pic_dat;
    logic              pic_ack;
    logic [`WB_DW-1:0] gpio_dat;
    logic              gpio_ack;

    modport dmem   (output dmem_dat, dmem_ack);
    modport pic    (output pic_dat, pic_ack);
    modport gpio   (output gpio_dat, gpio_ack);
    modport result (input dmem_dat, dmem_ack, pic_dat, pic_ack, gpio_dat, gpio_ack);
endinterface

//--- wb_addr_decode.sv
`include "system_config.svh"

module wb_addr_decode (
    input  logic              wb_clk_i,
    input  logic              rst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [`WB_AW-1:0] wb_adr_i,
    input  logic [`WB_SW-1:0] wb_sel_i,
    input  logic [`WB_DW-1:0] wb_dat_i,
    input  logic              done_i,
    wb_req_if.decoder         req
);
    import wb_pkg::*;

    dec_state_e        state_q;
    slave_sel_e        tgt_d;
    logic [SLV_GPIO:0] stb_d;
    logic              accept;

    // Requests are only taken while idle
    assign accept = wb_cyc_i && wb_stb_i && (state_q == DEC_IDLE);

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    always_comb begin
        tgt_d = SLV_NONE;
        stb_d = '0;
        case (wb_adr_i[15:12])
            `MAP_DMEM: begin
                tgt_d           = SLV_DMEM;
                stb_d[SLV_DMEM] = 1'b1;
            end
            `MAP_PIC: begin
                tgt_d          = SLV_PIC;
                stb_d[SLV_PIC] = 1'b1;
            end
            `MAP_GPIO: begin
                tgt_d           = SLV_GPIO;
                stb_d[SLV_GPIO] = 1'b1;
            end
            default: tgt_d = SLV_NONE;
        endcase
    end

    // ------------------------------------------------------------
    // Decoder FSM and one-cycle strobes
    // ------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= DEC_IDLE;
            req.stb   <= '0;
            req.issue <= 1'b0;
            req.tgt   <= SLV_NONE;
        end else begin
            req.stb   <= '0;
            req.issue <= 1'b0;
            case (state_q)
                DEC_IDLE: begin
                    if (accept) begin
                        state_q   <= DEC_WAIT;
                        req.stb   <= stb_d;
                        req.issue <= 1'b1;
                        req.tgt   <= tgt_d;
                    end
                end
                DEC_WAIT: begin
                    // Bus ack or error closes the access
                    if (done_i) begin
                        state_q <= DEC_IDLE;
                    end
                end
                default: state_q <= DEC_IDLE;
            endcase
        end
    end

    // Request fields held for the slaves
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            req.adr   <= wb_adr_i;
            req.dat_w <= wb_dat_i;
            req.sel   <= wb_sel_i;
            req.we    <= wb_we_i;
        end
    end

endmodule

//--- wb_data_ram.sv
`include "system_config.svh"

module wb_data_ram #(
    parameter int ADDR_W = `DMEM_AW
) (
    input  logic    wb_clk_i,
    input  logic    rst_n_i,
    wb_req_if.slave req,
    wb_rsp_if.dmem  rsp
);
    import wb_pkg::*;

    logic [`WB_DW-1:0] mem [2**ADDR_W];
    logic [ADDR_W-1:0] word_adr;
    logic              hit;

    // Word address starts above the byte offset
    assign word_adr = req.adr[ADDR_W+1:2];
    assign hit      = req.stb[SLV_DMEM];

    // ------------------------------------------------------------
    // Storage with byte lane writes
    // ------------------------------------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (hit) begin
            if (req.we) begin
                for (int i = 0; i < `WB_SW; i++) begin
                    if (req.sel[i]) begin
                        mem[word_adr][8*i +: 8] <= req.dat_w[8*i +: 8];
                    end
                end
            end
            // Old word on a write, full word on a read
            rsp.dmem_dat <= mem[word_adr];
        end
    end

    // One-cycle acknowledge for every strobe
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp.dmem_ack <= 1'b0;
        end else begin
            rsp.dmem_ack <= hit;
        end
    end

endmodule

//--- wb_pic.sv
`include "system_config.svh"

module wb_pic (
    input  logic              wb_clk_i,
    input  logic              rst_n_i,
    input  logic [`IRQ_W-1:0] irq_i,
    output logic              int_o,
    wb_req_if.slave           req,
    wb_rsp_if.pic             rsp
);
    import wb_pkg::*;

    reg_ofs_e          ofs;
    logic              hit;
    logic              wr_lane0;
    logic [`IRQ_W-1:0] clr;
    logic [`IRQ_W-1:0] pend_q;
    logic [`IRQ_W-1:0] mask_q;
    logic [`WB_DW-1:0] rd_d;

    assign ofs      = reg_ofs_e'(req.adr[3:2]);
    assign hit      = req.stb[SLV_PIC];
    // Registers live in the low byte
    assign wr_lane0 = hit && req.we && req.sel[0];

    // Write one to clear
    assign clr = (wr_lane0 && ofs == REG_PEND) ? req.dat_w[`IRQ_W-1:0] : '0;

    always_comb begin
        rd_d = '0;
        case (ofs)
            REG_PEND: rd_d[`IRQ_W-1:0] = pend_q;
            REG_MASK: rd_d[`IRQ_W-1:0] = mask_q;
            default:  rd_d = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Pending, mask and interrupt output
    // ------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q      <= '0;
            mask_q      <= '0;
            int_o       <= 1'b0;
            rsp.pic_ack <= 1'b0;
        end else begin
            // A new pulse wins over a clear in the same cycle
            pend_q <= (pend_q & ~clr) | irq_i;
            if (wr_lane0 && ofs == REG_MASK) begin
                mask_q <= req.dat_w[`IRQ_W-1:0];
            end
            int_o       <= |(pend_q & mask_q);
            rsp.pic_ack <= hit;
        end
    end

    // Read data captured with the strobe
    always_ff @(posedge wb_clk_i) begin
        if (hit) begin
            rsp.pic_dat <= rd_d;
        end
    end

endmodule

//--- wb_gpio.sv
`include "system_config.svh"

module wb_gpio (
    input  logic               wb_clk_i,
    input  logic               rst_n_i,
    input  logic [`GPIO_W-1:0] gpio_i,
    output logic [`GPIO_W-1:0] gpio_o,
    output logic [`GPIO_W-1:0] gpio_oe_o,
    wb_req_if.slave            req,
    wb_rsp_if.gpio             rsp
);
    import wb_pkg::*;

    reg_ofs_e           ofs;
    logic               hit;
    logic               wr_lane0;
    logic [`GPIO_W-1:0] sync1_q;
    logic [`GPIO_W-1:0] sync2_q;
    logic [`WB_DW-1:0]  rd_d;

    assign ofs      = reg_ofs_e'(req.adr[3:2]);
    assign hit      = req.stb[SLV_GPIO];
    assign wr_lane0 = hit && req.we && req.sel[0];

    always_comb begin
        rd_d = '0;
        case (ofs)
            REG_GPIO_OUT: rd_d[`GPIO_W-1:0] = gpio_o;
            REG_GPIO_DIR: rd_d[`GPIO_W-1:0] = gpio_oe_o;
            REG_GPIO_IN:  rd_d[`GPIO_W-1:0] = sync2_q;
            default:      rd_d = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Output and direction registers
    // ------------------------------------------------------------
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_o       <= '0;
            gpio_oe_o    <= '0;
            rsp.gpio_ack <= 1'b0;
        end else begin
            // Input register is read only
            if (wr_lane0 && ofs == REG_GPIO_OUT) begin
                gpio_o <= req.dat_w[`GPIO_W-1:0];
            end
            if (wr_lane0 && ofs == REG_GPIO_DIR) begin
                gpio_oe_o <= req.dat_w[`GPIO_W-1:0];
            end
            rsp.gpio_ack <= hit;
        end
    end

    // Two-flop input synchroniser and read capture
    always_ff @(posedge wb_clk_i) begin
        sync1_q <= gpio_i;
        sync2_q <= sync1_q;
        if (hit) begin
            rsp.gpio_dat <= rd_d;
        end
    end

endmodule

//--- wb_resp_mux.sv
`include "system_config.svh"

module wb_resp_mux (
    input  logic              wb_clk_i,
    input  logic              rst_n_i,
    output logic [`WB_DW-1:0] wb_dat_o,
    output logic              wb_ack_o,
    output logic              wb_err_o,
    output logic              done_o,
    wb_req_if.result          req,
    wb_rsp_if.result          rsp
);
    import wb_pkg::*;

    logic              issue_d;
    logic              ack_sel;
    logic              err_d;
    logic [`WB_DW-1:0] dat_sel;

    // ------------------------------------------------------------
    // Response select by target
    // ------------------------------------------------------------
    always_comb begin
        ack_sel = 1'b0;
        dat_sel = '0;
        case (req.tgt)
            SLV_DMEM: begin
                ack_sel = rsp.dmem_ack;
                dat_sel = rsp.dmem_dat;
            end
            SLV_PIC: begin
                ack_sel = rsp.pic_ack;
                dat_sel = rsp.pic_dat;
            end
            SLV_GPIO: begin
                ack_sel = rsp.gpio_ack;
                dat_sel = rsp.gpio_dat;
            end
            default: dat_sel = '0;
        endcase
    end

    // Unmapped access errors where a slave would have acked
    assign err_d = issue_d && (req.tgt == SLV_NONE);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_d  <= 1'b0;
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            issue_d  <= req.issue;
            wb_ack_o <= ack_sel;
            wb_err_o <= err_d;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (ack_sel || err_d) begin
            wb_dat_o <= dat_sel;
        end
    end

    assign done_o = wb_ack_o || wb_err_o;

endmodule

//--- wb_system.sv
`include "system_config.svh"

module wb_system (
    input  logic               wb_clk_i,
    input  logic               rst_n_i,

    // Wishbone master port
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [`WB_AW-1:0]  wb_adr_i,
    input  logic [`WB_SW-1:0]  wb_sel_i,
    input  logic [`WB_DW-1:0]  wb_dat_i,
    output logic [`WB_DW-1:0]  wb_dat_o,
    output logic               wb_ack_o,
    output logic               wb_err_o,

    // Interrupts
    input  logic [`IRQ_W-1:0]  irq_i,
    output logic               int_o,

    // GPIO pads, split into in, out and enable
    input  logic [`GPIO_W-1:0] gpio_i,
    output logic [`GPIO_W-1:0] gpio_o,
    output logic [`GPIO_W-1:0] gpio_oe_o
);

    logic done;

    wb_req_if req_if ();
    wb_rsp_if rsp_if ();

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    wb_addr_decode u_decode (
        .wb_clk_i ( wb_clk_i       ),
        .rst_n_i  ( rst_n_i        ),
        .wb_cyc_i ( wb_cyc_i       ),
        .wb_stb_i ( wb_stb_i       ),
        .wb_we_i  ( wb_we_i        ),
        .wb_adr_i ( wb_adr_i       ),
        .wb_sel_i ( wb_sel_i       ),
        .wb_dat_i ( wb_dat_i       ),
        .done_i   ( done           ),
        .req      ( req_if.decoder )
    );

    // ------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------
    wb_data_ram #(
        .ADDR_W ( `DMEM_AW )
    ) u_dmem (
        .wb_clk_i ( wb_clk_i     ),
        .rst_n_i  ( rst_n_i      ),
        .req      ( req_if.slave ),
        .rsp      ( rsp_if.dmem  )
    );

    wb_pic u_pic (
        .wb_clk_i ( wb_clk_i     ),
        .rst_n_i  ( rst_n_i      ),
        .irq_i    ( irq_i        ),
        .int_o    ( int_o        ),
        .req      ( req_if.slave ),
        .rsp      ( rsp_if.pic   )
    );

    wb_gpio u_gpio (
        .wb_clk_i  ( wb_clk_i     ),
        .rst_n_i   ( rst_n_i      ),
        .gpio_i    ( gpio_i       ),
        .gpio_o    ( gpio_o       ),
        .gpio_oe_o ( gpio_oe_o    ),
        .req       ( req_if.slave ),
        .rsp       ( rsp_if.gpio  )
    );

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    wb_resp_mux u_resp (
        .wb_clk_i ( wb_clk_i      ),
        .rst_n_i  ( rst_n_i       ),
        .wb_dat_o ( wb_dat_o      ),
        .wb_ack_o ( wb_ack_o      ),
        .wb_err_o ( wb_err_o      ),
        .done_o   ( done          ),
        .req      ( req_if.result ),
        .rsp      ( rsp_if.result )
    );

endmodule

//--- tb_wb_system.sv
`include "system_config.svh"

module tb_wb_system;
    timeunit 1ns;
    timeprecision 1ps;

    parameter int unsigned SEED = 32'h1c7b_05d2;

    localparam int          WAIT_LIMIT = 20;
    localparam logic [31:0] PIC_PEND   = {16'h0000, `MAP_PIC, 12'h000};
    localparam logic [31:0] PIC_MASK   = {16'h0000, `MAP_PIC, 12'h004};
    localparam logic [31:0] GPIO_OUT   = {16'h0000, `MAP_GPIO, 12'h000};
    localparam logic [31:0] GPIO_DIR   = {16'h0000, `MAP_GPIO, 12'h004};
    localparam logic [31:0] GPIO_IN    = {16'h0000, `MAP_GPIO, 12'h008};

    logic               wb_clk_i = 1'b0;
    logic               rst_n_i, wb_cyc_i, wb_stb_i, wb_we_i;
    logic [`WB_AW-1:0]  wb_adr_i;
    logic [`WB_SW-1:0]  wb_sel_i;
    logic [`WB_DW-1:0]  wb_dat_i, wb_dat_o;
    logic               wb_ack_o, wb_err_o, int_o;
    logic [`IRQ_W-1:0]  irq_i;
    logic [`GPIO_W-1:0] gpio_i, gpio_o, gpio_oe_o;

    // Reference model state
    logic [31:0] ram_model [2**`DMEM_AW];
    logic [7:0]  pend_model, mask_model, out_model, dir_model;
    logic [9:0]  pool [16];
    logic [31:0] r, d, rdat;
    logic        err;
    int          checks, errors, start_errors, writes;

    wb_system wb_system_i (.*);

    initial begin
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One classic cycle started and ended on a falling edge
    task automatic bus_access(input string name, input logic we, input logic [31:0] adr,
                              input logic [3:0] sel, input logic [31:0] dat,
                              output logic [31:0] rd, output logic er);
        int cycles;
        cycles   = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_sel_i = sel;
        wb_dat_i = dat;
        while (cycles < WAIT_LIMIT && !(wb_ack_o || wb_err_o)) begin
            @(negedge wb_clk_i);
            cycles++;
        end
        if (!(wb_ack_o || wb_err_o)) begin
            errors++;
            $display("Timeout: %0s at address %h got no ack or error in %0d cycles",
                     name, adr, cycles);
            $display("** FAIL **");
            $finish;
        end else begin
            rd = wb_dat_o;
            er = wb_err_o;
            // Response is due in the cycle after edge 2
            check($sformatf("%0s latency", name), 32'd3, cycles);
            check($sformatf("%0s ack with err", name), 0, {31'd0, wb_ack_o & wb_err_o});
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
            @(negedge wb_clk_i);
            check($sformatf("%0s response width", name), 0, {30'd0, wb_ack_o, wb_err_o});
        end
    endtask

    // RAM byte address with random undecoded upper bits
    function automatic logic [31:0] ram_adr(input logic [9:0] word);
        logic [31:0] u;
        u = $urandom();
        return {u[31:16], `MAP_DMEM, word, 2'b00};
    endfunction

    task automatic report_test(input string name);
        $display("test %0s finished with %0d errors", name, errors - start_errors);
        start_errors = errors;
    endtask

    initial begin
        void'($urandom(SEED));
        checks = 0;
        errors = 0;
        start_errors = 0;
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        irq_i    = '0;
        gpio_i   = '0;
        repeat (5) @(negedge wb_clk_i);
        rst_n_i = 1'b1;

        // ------------------------------------------------------------
        // Reset values
        // ------------------------------------------------------------
        check("reset ack", 0, {31'd0, wb_ack_o});
        check("reset err", 0, {31'd0, wb_err_o});
        check("reset int_o", 0, {31'd0, int_o});
        check("reset gpio_o", 0, {24'd0, gpio_o});
        check("reset gpio_oe_o", 0, {24'd0, gpio_oe_o});
        report_test("reset");

        // ------------------------------------------------------------
        // Data RAM fill of a small pool then lane writes
        // ------------------------------------------------------------
        for (int i = 0; i < 16; i++) begin
            r = $urandom();
            pool[i] = r[9:0];
            d = $urandom();
            bus_access("ram fill", 1'b1, ram_adr(pool[i]), 4'hf, d, rdat, err);
            ram_model[pool[i]] = d;
        end
        writes = 0;
        while (writes < 200) begin
            r = $urandom();
            if (r[4]) begin
                d = $urandom();
                bus_access("ram write", 1'b1, ram_adr(pool[r[3:0]]), r[11:8], d, rdat, err);
                for (int b = 0; b < 4; b++) begin
                    if (r[8+b]) ram_model[pool[r[3:0]]][8*b +: 8] = d[8*b +: 8];
                end
                writes++;
            end else begin
                bus_access("ram read", 1'b0, ram_adr(pool[r[3:0]]), r[11:8], 32'h0, rdat, err);
                check("ram read data", ram_model[pool[r[3:0]]], rdat);
            end
            check("ram err", 0, {31'd0, err});
        end
        report_test("ram");

        // Unmapped regions 3 to 15
        for (int n = 0; n < 20; n++) begin
            r = $urandom();
            bus_access("unmapped", r[0], {r[31:16], 4'($urandom_range(15, 3)), r[15:4]},
                       4'hf, $urandom(), rdat, err);
            check("unmapped err", 1, {31'd0, err});
            check("unmapped data", 0, rdat);
        end
        report_test("unmapped");

        // ------------------------------------------------------------
        // Interrupt controller
        // ------------------------------------------------------------
        bus_access("pic clear", 1'b1, PIC_PEND, 4'h1, 32'hff, rdat, err);
        pend_model = '0;
        for (int n = 0; n < 20; n++) begin
            r = $urandom();
            repeat (r[2:0] + 1) begin
                d = $urandom();
                irq_i = d[7:0] & d[15:8];
                pend_model |= irq_i;
                @(negedge wb_clk_i);
                irq_i = '0;
                @(negedge wb_clk_i);
            end
            bus_access("pic pend read", 1'b0, PIC_PEND, 4'hf, 32'h0, rdat, err);
            check("pic pend", {24'd0, pend_model}, rdat);
            d = $urandom();
            mask_model = d[7:0];
            bus_access("pic mask write", 1'b1, PIC_MASK, 4'h1, d, rdat, err);
            check("pic int after mask", {31'd0, |(pend_model & mask_model)}, {31'd0, int_o});
            bus_access("pic mask read", 1'b0, PIC_MASK, 4'hf, 32'h0, rdat, err);
            check("pic mask", {24'd0, mask_model}, rdat);
            d = $urandom();
            pend_model &= ~d[7:0];
            bus_access("pic clear", 1'b1, PIC_PEND, 4'h1, d, rdat, err);
            check("pic int after clear", {31'd0, |(pend_model & mask_model)}, {31'd0, int_o});
            bus_access("pic pend read", 1'b0, PIC_PEND, 4'hf, 32'h0, rdat, err);
            check("pic pend after clear", {24'd0, pend_model}, rdat);
        end
        report_test("pic");

        // ------------------------------------------------------------
        // GPIO
        // ------------------------------------------------------------
        out_model = '0;
        dir_model = '0;
        for (int n = 0; n < 20; n++) begin
            r = $urandom();
            d = $urandom();
            bus_access("gpio write", 1'b1, r[0] ? GPIO_DIR : GPIO_OUT, r[7:4], d, rdat, err);
            // Only lane 0 carries register data
            if (r[4] && r[0]) dir_model = d[7:0];
            if (r[4] && !r[0]) out_model = d[7:0];
            check("gpio_o", {24'd0, out_model}, {24'd0, gpio_o});
            check("gpio_oe_o", {24'd0, dir_model}, {24'd0, gpio_oe_o});
            bus_access("gpio reg read", 1'b0, r[0] ? GPIO_DIR : GPIO_OUT, 4'hf, 32'h0,
                       rdat, err);
            check("gpio reg read", {24'd0, (r[0] ? dir_model : out_model)}, rdat);
            r = $urandom();
            gpio_i = r[7:0];
            repeat (4) @(negedge wb_clk_i);
            bus_access("gpio in read", 1'b0, GPIO_IN, 4'hf, 32'h0, rdat, err);
            check("gpio in", {24'd0, r[7:0]}, rdat);
            bus_access("gpio in write", 1'b1, GPIO_IN, 4'hf, $urandom(), rdat, err);
            check("gpio_o after in write", {24'd0, out_model}, {24'd0, gpio_o});
            check("gpio_oe_o after in write", {24'd0, dir_model}, {24'd0, gpio_oe_o});
        end
        report_test("gpio");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
wb_pkg.sv
wb_bus_if.sv
wb_addr_decode.sv
wb_data_ram.sv
wb_pic.sv
wb_gpio.sv
wb_resp_mux.sv
wb_system.sv
tb_wb_system.sv

//--- Makefile
# Verilator simulation of the Wishbone subsystem

TOP       ?= tb_wb_system
SEED      ?= 477824466
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f

.PHONY: sim clean

# Build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -x -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
